//--- verilog/rx_pnmon_pkg.sv
package rx_pnmon_pkg;

  // Sample and sequence widths.
  typedef logic [11:0] iq_sample_t;
  typedef logic [15:0] pn_word_t;

  // One I/Q sample pair as delivered by the ADC.
  typedef struct packed {
    iq_sample_t i;
    iq_sample_t q;
  } adc_iq_t;

  // Register port types.
  typedef logic [1:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  typedef struct packed {
    logic      write;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  // Sync machine of the PN monitor.
  typedef enum logic {
    PN_SEEK,
    PN_LOCKED
  } pn_state_t;

  // State flips on the update that finds the run counter at this value.
  localparam int PN_SYNC_COUNT = 16;

  // Register map.
  localparam reg_addr_t REG_CONTROL   = 2'd0;
  localparam reg_addr_t REG_STATUS    = 2'd1;
  localparam reg_addr_t REG_ERR_COUNT = 2'd2;
  localparam reg_addr_t REG_ID        = 2'd3;

  // Reads back as "PN".
  localparam reg_data_t PN_ID_VALUE = 16'h504e;

endpackage

//--- verilog/rx_pn_checker.sv
`timescale 1ns/1ps

module rx_pn_checker (
  input  logic                  adc_clk,
  input  logic                  reset,
  input  logic                  enable,
  input  logic                  adc_valid,
  input  rx_pnmon_pkg::adc_iq_t adc_iq,
  output logic                  pn_oos,
  output logic                  pn_err
);

  // Next word of the inverted PN16 sequence.
  function automatic rx_pnmon_pkg::pn_word_t pn_next(
    input rx_pnmon_pkg::pn_word_t word
  );
    return {word[14:0], ~((^word[15:4]) ^ (^word[2:1]))};
  endfunction

  function automatic rx_pnmon_pkg::iq_sample_t bit_reverse(
    input rx_pnmon_pkg::iq_sample_t value
  );
    rx_pnmon_pkg::iq_sample_t result;
    for (int n = 0; n < $bits(value); n++) begin
      result[n] = value[$bits(value) - 1 - n];
    end
    return result;
  endfunction

  rx_pnmon_pkg::iq_sample_t data_i;
  rx_pnmon_pkg::iq_sample_t data_q;
  rx_pnmon_pkg::iq_sample_t data_q_rev;
  rx_pnmon_pkg::pn_word_t   data_word;
  rx_pnmon_pkg::pn_word_t   prev_word;
  rx_pnmon_pkg::pn_word_t   pred_word;
  rx_pnmon_pkg::pn_word_t   pred_seed;
  rx_pnmon_pkg::pn_state_t  state;

  logic       iq_match_c;
  logic       pred_match_c;
  logic       change_c;
  logic       valid_d;
  logic       iq_match_q;
  logic       pred_match_q;
  logic       change_q;
  logic       pn_match;
  logic       pn_update;
  logic [4:0] run_count;

  // Undo the inversion on both channels and the bit order on Q.
  assign data_i     = ~adc_iq.i;
  assign data_q     = ~adc_iq.q;
  assign data_q_rev = bit_reverse(data_q);
  assign data_word  = {data_i, data_q_rev[3:0]};

  // The overlapping byte of I and Q must carry the same bits.
  assign iq_match_c   = (data_i[7:0] == data_q_rev[11:4]);
  assign pred_match_c = (data_word == pred_word);
  // A stuck input repeats the same word.
  assign change_c     = (data_word != prev_word);

  // While seeking, predict from the incoming sample itself.
  assign pred_seed = (state == rx_pnmon_pkg::PN_SEEK) ? data_word : pred_word;

  always_ff @(posedge adc_clk) begin
    if (adc_valid) begin
      prev_word <= data_word;
      pred_word <= pn_next(pred_seed);
    end
    iq_match_q   <= iq_match_c;
    pred_match_q <= pred_match_c;
    change_q     <= change_c;
  end

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      valid_d <= 1'b0;
    end else begin
      valid_d <= adc_valid;
    end
  end

  assign pn_match = iq_match_q & pred_match_q & change_q;

  // Match while seeking or mismatch while locked moves toward a state change.
  assign pn_update = (pn_match == (state == rx_pnmon_pkg::PN_SEEK));

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      state     <= rx_pnmon_pkg::PN_SEEK;
      run_count <= '0;
      pn_err    <= 1'b0;
    end else begin
      pn_err <= valid_d & enable & (state == rx_pnmon_pkg::PN_LOCKED) & ~pn_match;
      if (valid_d && enable) begin
        if (pn_update) begin
          if (run_count >= rx_pnmon_pkg::PN_SYNC_COUNT) begin
            run_count <= '0;
            state     <= (state == rx_pnmon_pkg::PN_SEEK) ? rx_pnmon_pkg::PN_LOCKED
                                                          : rx_pnmon_pkg::PN_SEEK;
          end else begin
            run_count <= run_count + 5'd1;
          end
        end else begin
          run_count <= '0;
        end
      end
    end
  end

  assign pn_oos = (state == rx_pnmon_pkg::PN_SEEK);

endmodule

//--- verilog/rx_pn_status_regs.sv
`timescale 1ns/1ps

module rx_pn_status_regs (
  input  logic                    adc_clk,
  input  logic                    reset,
  input  rx_pnmon_pkg::reg_req_t  reg_req,
  input  logic                    reg_req_valid,
  output logic                    reg_req_ready,
  output rx_pnmon_pkg::reg_data_t reg_rdata,
  output logic                    reg_rsp_valid,
  input  logic                    pn_oos,
  input  logic                    pn_err,
  output logic                    enable
);

  rx_pnmon_pkg::reg_data_t err_count;
  rx_pnmon_pkg::reg_data_t read_value;

  logic accept;
  logic wr_control;
  logic wr_status;
  logic wr_err_count;
  logic sticky_err;
  logic clear_sticky;

  // One read in flight at most, so no new request in the response cycle.
  assign reg_req_ready = ~reg_rsp_valid;
  assign accept        = reg_req_valid & reg_req_ready;

  assign wr_control   = accept & reg_req.write & (reg_req.addr == rx_pnmon_pkg::REG_CONTROL);
  assign wr_status    = accept & reg_req.write & (reg_req.addr == rx_pnmon_pkg::REG_STATUS);
  assign wr_err_count = accept & reg_req.write & (reg_req.addr == rx_pnmon_pkg::REG_ERR_COUNT);

  // Write one to clear.
  assign clear_sticky = wr_status & reg_req.wdata[1];

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      enable <= 1'b1;
    end else if (wr_control) begin
      enable <= reg_req.wdata[0];
    end
  end

  // A new error wins over a clear in the same cycle.
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      sticky_err <= 1'b0;
    end else if (pn_err) begin
      sticky_err <= 1'b1;
    end else if (clear_sticky) begin
      sticky_err <= 1'b0;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      err_count <= '0;
    end else if (wr_err_count) begin
      err_count <= rx_pnmon_pkg::reg_data_t'(pn_err);
    end else if (pn_err && (err_count != '1)) begin
      err_count <= err_count + 1'b1;
    end
  end

  always_comb begin
    case (reg_req.addr)
      rx_pnmon_pkg::REG_CONTROL: begin
        read_value = {15'd0, enable};
      end
      rx_pnmon_pkg::REG_STATUS: begin
        read_value = {14'd0, sticky_err, pn_oos};
      end
      rx_pnmon_pkg::REG_ERR_COUNT: begin
        read_value = err_count;
      end
      default: begin
        read_value = rx_pnmon_pkg::PN_ID_VALUE;
      end
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      reg_rsp_valid <= 1'b0;
    end else begin
      reg_rsp_valid <= accept & ~reg_req.write;
    end
  end

  // Read data is captured when the request is accepted.
  always_ff @(posedge adc_clk) begin
    if (accept && !reg_req.write) begin
      reg_rdata <= read_value;
    end
  end

endmodule

//--- verilog/rx_pnmon_top.sv
`timescale 1ns/1ps

module rx_pnmon_top (
  input  logic                    adc_clk,
  input  logic                    reset,
  input  logic                    adc_valid,
  input  rx_pnmon_pkg::adc_iq_t   adc_iq,
  input  rx_pnmon_pkg::reg_req_t  reg_req,
  input  logic                    reg_req_valid,
  output logic                    reg_req_ready,
  output rx_pnmon_pkg::reg_data_t reg_rdata,
  output logic                    reg_rsp_valid,
  output logic                    pn_oos,
  output logic                    pn_err
);

  logic enable;

  rx_pn_checker i_checker (
    .adc_clk   (adc_clk),
    .reset     (reset),
    .enable    (enable),
    .adc_valid (adc_valid),
    .adc_iq    (adc_iq),
    .pn_oos    (pn_oos),
    .pn_err    (pn_err)
  );

  // Software control and error bookkeeping.
  rx_pn_status_regs i_status_regs (
    .adc_clk       (adc_clk),
    .reset         (reset),
    .reg_req       (reg_req),
    .reg_req_valid (reg_req_valid),
    .reg_req_ready (reg_req_ready),
    .reg_rdata     (reg_rdata),
    .reg_rsp_valid (reg_rsp_valid),
    .pn_oos        (pn_oos),
    .pn_err        (pn_err),
    .enable        (enable)
  );

endmodule

//--- tb/rx_pnmon_asserts.sv
`timescale 1ns/1ps

module rx_pnmon_asserts (
  input logic                   adc_clk,
  input logic                   reset,
  input rx_pnmon_pkg::reg_req_t reg_req,
  input logic                   reg_req_valid,
  input logic                   reg_req_ready,
  input logic                   reg_rsp_valid,
  input logic                   pn_oos,
  input logic                   pn_err
);

  int unsigned failures = 0;
  logic        reset_q;
  logic        read_accept;

  assign read_accept = reg_req_valid & reg_req_ready & ~reg_req.write;

  // Second cycle of reset onward, once the state has been loaded.
  always_ff @(posedge adc_clk) begin
    reset_q <= reset;
  end

  err_needs_lock: assert property (@(posedge adc_clk) disable iff (reset)
    pn_err |-> !$past(pn_oos, 2))
    else begin
      $error("pn_err high while pn_oos was high two cycles before");
      failures++;
    end

  rsp_after_read: assert property (@(posedge adc_clk) disable iff (reset)
    read_accept |=> reg_rsp_valid)
    else begin
      $error("no reg_rsp_valid one cycle after an accepted read");
      failures++;
    end

  rsp_only_after_read: assert property (@(posedge adc_clk) disable iff (reset)
    reg_rsp_valid |-> $past(read_accept))
    else begin
      $error("reg_rsp_valid without an accepted read before it");
      failures++;
    end

  no_ready_in_rsp: assert property (@(posedge adc_clk) disable iff (reset)
    reg_rsp_valid |-> !reg_req_ready)
    else begin
      $error("reg_req_ready high in a response cycle");
      failures++;
    end

  reset_outputs: assert property (@(posedge adc_clk)
    (reset && reset_q) |-> (pn_oos && !pn_err))
    else begin
      $error("pn_oos or pn_err wrong during reset");
      failures++;
    end

endmodule

bind rx_pnmon_top rx_pnmon_asserts i_asserts (.*);

//--- tb/rx_pnmon_tb.sv
`timescale 1ns/1ps

module rx_pnmon_tb;

  localparam logic [31:0] SEED = 32'h98356c3a;
  localparam int SYNC = rx_pnmon_pkg::PN_SYNC_COUNT;
  // Rough cycle budget of reset and the six tests.
  localparam int TEST_CYCLES = 16 + 60 + 50 + 30 + 140 + 70 + 30;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                    adc_clk = 1'b0;
  logic                    reset;
  logic                    adc_valid;
  rx_pnmon_pkg::adc_iq_t   adc_iq;
  rx_pnmon_pkg::reg_req_t  reg_req;
  logic                    reg_req_valid;
  logic                    reg_req_ready;
  rx_pnmon_pkg::reg_data_t reg_rdata;
  logic                    reg_rsp_valid;
  logic                    pn_oos;
  logic                    pn_err;

  rx_pnmon_pkg::pn_word_t  pn_word;
  logic [31:0]             rng;
  int errors = 0;
  int err_pulses = 0;
  int cycle_count = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int model_count = 0;
  int pulses_start;
  int test_start;

  rx_pnmon_top i_dut (
    .adc_clk       (adc_clk),
    .reset         (reset),
    .adc_valid     (adc_valid),
    .adc_iq        (adc_iq),
    .reg_req       (reg_req),
    .reg_req_valid (reg_req_valid),
    .reg_req_ready (reg_req_ready),
    .reg_rdata     (reg_rdata),
    .reg_rsp_valid (reg_rsp_valid),
    .pn_oos        (pn_oos),
    .pn_err        (pn_err)
  );

  always #20 adc_clk = ~adc_clk;

  always @(posedge adc_clk) begin
    if (!reset && pn_err) begin
      err_pulses <= err_pulses + 1;
    end
  end

  always @(posedge adc_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state ^ (state << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Shift left, feed back the inverted parity of taps 15..4 and 2..1.
  function automatic rx_pnmon_pkg::pn_word_t pn_next_word(input rx_pnmon_pkg::pn_word_t w);
    return {w[14:0], ~(^{w[15:4], w[2:1]})};
  endfunction

  function automatic rx_pnmon_pkg::adc_iq_t make_sample(input rx_pnmon_pkg::pn_word_t w);
    rx_pnmon_pkg::adc_iq_t sample;
    sample.i = ~w[15:4];
    for (int n = 0; n < 12; n++) begin
      sample.q[n] = ~w[11 - n];
    end
    return sample;
  endfunction

  function automatic rx_pnmon_pkg::reg_req_t make_request(input logic write,
      input rx_pnmon_pkg::reg_addr_t addr, input rx_pnmon_pkg::reg_data_t wdata);
    rx_pnmon_pkg::reg_req_t req;
    req.write = write;
    req.addr  = addr;
    req.wdata = wdata;
    return req;
  endfunction

  function automatic int total_errors();
    return errors + i_dut.i_asserts.failures;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // Random gap, then one sample of the running word, corrupted if asked.
  task automatic send_sample(input logic corrupt);
    rx_pnmon_pkg::adc_iq_t sample;
    rng = xorshift32(rng);
    if (rng[1:0] == 2'b00) begin
      @(posedge adc_clk);
      adc_valid <= 1'b0;
    end
    sample = make_sample(pn_word);
    if (corrupt) begin
      rng = xorshift32(rng);
      sample = sample ^ ((rng[23:0] == 24'd0) ? 24'd1 : rng[23:0]);
    end
    @(posedge adc_clk);
    adc_valid <= 1'b1;
    adc_iq    <= sample;
    pn_word = pn_next_word(pn_word);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge adc_clk);
      adc_valid <= 1'b0;
    end
  endtask

  task automatic wait_oos(input logic expected);
    int n = 0;
    while (pn_oos !== expected && n < 8) begin
      @(posedge adc_clk);
      adc_valid <= 1'b0;
      n++;
    end
    if (pn_oos !== expected) begin
      $display("pn_oos did not change to %0b within 8 cycles", expected);
      errors++;
    end
  endtask

  task automatic accept_request();
    int n = 0;
    do begin
      @(posedge adc_clk);
      n++;
    end while (!reg_req_ready && n < 8);
    if (!reg_req_ready) begin
      $display("register request was not accepted within 8 cycles");
      errors++;
    end
  endtask

  task automatic wait_response(output rx_pnmon_pkg::reg_data_t data);
    int n = 0;
    do begin
      @(posedge adc_clk);
      n++;
    end while (!reg_rsp_valid && n < 4);
    data = reg_rdata;
    if (!reg_rsp_valid) begin
      $display("no read response within 4 cycles");
      errors++;
    end
  endtask

  task automatic reg_write(input rx_pnmon_pkg::reg_addr_t addr,
      input rx_pnmon_pkg::reg_data_t data);
    @(posedge adc_clk);
    reg_req       <= make_request(1'b1, addr, data);
    reg_req_valid <= 1'b1;
    accept_request();
    reg_req_valid <= 1'b0;
  endtask

  task automatic read_expect(input rx_pnmon_pkg::reg_addr_t addr,
      input rx_pnmon_pkg::reg_data_t exp);
    rx_pnmon_pkg::reg_data_t data;
    @(posedge adc_clk);
    reg_req       <= make_request(1'b0, addr, '0);
    reg_req_valid <= 1'b1;
    accept_request();
    reg_req_valid <= 1'b0;
    wait_response(data);
    check_value("reg_rdata", data, exp);
  endtask

  task automatic read_back_to_back(input rx_pnmon_pkg::reg_addr_t addr_a,
      input rx_pnmon_pkg::reg_data_t exp_a, input rx_pnmon_pkg::reg_addr_t addr_b,
      input rx_pnmon_pkg::reg_data_t exp_b);
    rx_pnmon_pkg::reg_data_t data;
    @(posedge adc_clk);
    reg_req       <= make_request(1'b0, addr_a, '0);
    reg_req_valid <= 1'b1;
    accept_request();
    // Second read is already waiting in the response cycle.
    reg_req <= make_request(1'b0, addr_b, '0);
    @(posedge adc_clk);
    check_value("reg_rsp_valid", reg_rsp_valid, 1);
    check_value("reg_req_ready", reg_req_ready, 0);
    check_value("reg_rdata", reg_rdata, exp_a);
    accept_request();
    reg_req_valid <= 1'b0;
    wait_response(data);
    check_value("reg_rdata", data, exp_b);
  endtask

  task automatic end_test(input string name);
    int failed;
    failed = total_errors() - test_start;
    tests_run++;
    if (failed != 0) begin
      tests_failed++;
    end
    $display("test %0d %s: %s (%0d errors)", tests_run, name, failed ? "failed" : "ok", failed);
    test_start = total_errors();
    pulses_start = err_pulses;
  endtask

  initial begin
    reset         = 1'b1;
    adc_valid     = 1'b0;
    adc_iq        = '0;
    reg_req       = '0;
    reg_req_valid = 1'b0;
    rng           = SEED;
    pn_word       = 16'hace1;
    repeat (16) @(posedge adc_clk);
    reset <= 1'b0;
    test_start   = 0;
    pulses_start = 0;

    // First compare plus seventeen updates.
    check_value("pn_oos", pn_oos, 1);
    repeat (SYNC + 1) send_sample(1'b0);
    idle(4);
    check_value("pn_oos", pn_oos, 1);
    send_sample(1'b0);
    wait_oos(1'b0);
    idle(4);
    check_value("pn_err pulses", err_pulses - pulses_start, 0);
    end_test("lock");

    repeat (3) send_sample(1'b0);
    send_sample(1'b1);
    repeat (4) send_sample(1'b0);
    idle(4);
    check_value("pn_err pulses", err_pulses - pulses_start, 1);
    check_value("pn_oos", pn_oos, 0);
    model_count = 1;
    read_expect(rx_pnmon_pkg::REG_ERR_COUNT, model_count);
    read_expect(rx_pnmon_pkg::REG_STATUS, 16'h0002);
    end_test("single error");

    reg_write(rx_pnmon_pkg::REG_STATUS, 16'h0002);
    reg_write(rx_pnmon_pkg::REG_ERR_COUNT, 16'h5a5a);
    model_count = 0;
    read_expect(rx_pnmon_pkg::REG_STATUS, 16'h0000);
    read_expect(rx_pnmon_pkg::REG_ERR_COUNT, 16'h0000);
    read_expect(rx_pnmon_pkg::REG_ID, 16'h504e);
    end_test("clear");

    // Every mismatch while locked pulses, the seventeenth one included.
    repeat (SYNC) send_sample(1'b1);
    idle(4);
    check_value("pn_oos", pn_oos, 0);
    send_sample(1'b1);
    wait_oos(1'b1);
    idle(4);
    check_value("pn_err pulses", err_pulses - pulses_start, SYNC + 1);
    model_count += SYNC + 1;
    pulses_start = err_pulses;
    repeat (20) send_sample(1'b1);
    idle(4);
    check_value("pn_err pulses", err_pulses - pulses_start, 0);
    check_value("pn_oos", pn_oos, 1);
    read_expect(rx_pnmon_pkg::REG_ERR_COUNT, model_count);
    end_test("loss of sync");

    repeat (SYNC + 2) send_sample(1'b0);
    wait_oos(1'b0);
    reg_write(rx_pnmon_pkg::REG_CONTROL, 16'h0000);
    pulses_start = err_pulses;
    repeat (4) begin
      send_sample(1'b1);
      send_sample(1'b0);
    end
    idle(4);
    check_value("pn_err pulses", err_pulses - pulses_start, 0);
    check_value("pn_oos", pn_oos, 0);
    read_expect(rx_pnmon_pkg::REG_ERR_COUNT, model_count);
    reg_write(rx_pnmon_pkg::REG_CONTROL, 16'h0001);
    read_expect(rx_pnmon_pkg::REG_CONTROL, 16'h0001);
    pulses_start = err_pulses;
    send_sample(1'b1);
    repeat (3) send_sample(1'b0);
    idle(4);
    check_value("pn_err pulses", err_pulses - pulses_start, 1);
    model_count += 1;
    read_expect(rx_pnmon_pkg::REG_ERR_COUNT, model_count);
    end_test("disable");

    read_back_to_back(rx_pnmon_pkg::REG_STATUS, 16'h0002,
                      rx_pnmon_pkg::REG_ERR_COUNT, model_count);
    read_back_to_back(rx_pnmon_pkg::REG_ID, 16'h504e, rx_pnmon_pkg::REG_CONTROL, 16'h0001);
    end_test("back-pressure");

    $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, i_dut.i_asserts.failures);
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- rx_pnmon.f
verilog/rx_pnmon_pkg.sv
verilog/rx_pn_checker.sv
verilog/rx_pn_status_regs.sv
verilog/rx_pnmon_top.sv
tb/rx_pnmon_asserts.sv
tb/rx_pnmon_tb.sv

//--- Bender.yml
package:
  name: rx_pnmon

sources:
  - files:
      - verilog/rx_pnmon_pkg.sv
      - verilog/rx_pn_checker.sv
      - verilog/rx_pn_status_regs.sv
      - verilog/rx_pnmon_top.sv
  - target: test
    files:
      - tb/rx_pnmon_asserts.sv
      - tb/rx_pnmon_tb.sv
